// ==== hdl/mmu_pkg.sv ====
////////////////////////////////////////
// Sv32 MMU widths, TLB geometry and PTE types
// Used by scoped name from the RTL and testbench
////////////////////////////////////////

package mmu_pkg;

    // Address and page number widths
    localparam int VALEN = 32;
    localparam int PALEN = 34;
    localparam int PPN_W = 22;
    localparam int VPN_W = 20;

    // TLB geometry, same for ITLB and DTLB
    localparam int TLB_ENTRIES = 8;
    localparam int TLB_IDX_W   = 3;

    // One PTE word, whole page number or split per level
    // The split view serves superpage alignment checks
    typedef union packed {
        struct packed {
            logic [PPN_W-1:0] ppn;
            logic [1:0]       rsw;
            logic             d;
            logic             a;
            logic             g;
            logic             u;
            logic             x;
            logic             w;
            logic             r;
            logic             v;
        } flat;
        struct packed {
            logic [11:0]      ppn1;
            logic [9:0]       ppn0;
            logic [1:0]       rsw;
            logic             d;
            logic             a;
            logic             g;
            logic             u;
            logic             x;
            logic             w;
            logic             r;
            logic             v;
        } split;
    } sv32_pte_u;

    // Page-table walker states
    typedef enum logic [1:0] {
        IDLE,
        L1_REQ,
        L0_REQ,
        FILL
    } ptw_state_e;

endpackage

// ==== hdl/tlb_if.sv ====
////////////////////////////////////////
// Link between the MMU top, one TLB and the walker
// Carries lookup, lookup result and fill signals
////////////////////////////////////////

`timescale 1ns/1ns

interface tlb_if;

    // Lookup request from the MMU
    logic                      req;
    logic [mmu_pkg::VPN_W-1:0] vpn;
    logic                      flush;

    // Lookup result, combinational on vpn
    logic                      match;
    logic [mmu_pkg::PPN_W-1:0] ppn;
    logic                      page_4m;
    logic                      r;
    logic                      w;
    logic                      x;

    // Fill from the page-table walker
    logic                      fill;
    logic [mmu_pkg::VPN_W-1:0] fill_vpn;
    mmu_pkg::sv32_pte_u        fill_pte;
    logic                      fill_4m;

    modport mmu (output req, vpn, flush, input match, ppn, page_4m, r, w, x);

    modport tlb (
        input  req, vpn, flush, fill, fill_vpn, fill_pte, fill_4m,
        output match, ppn, page_4m, r, w, x
    );

    modport walker (output fill, fill_vpn, fill_pte, fill_4m);

endinterface

// ==== hdl/tlb.sv ====
////////////////////////////////////////
// Fully associative TLB for Sv32 translation
// Instantiated once per side, filled by the walker
////////////////////////////////////////

`timescale 1ns/1ns

module tlb (
    input  logic clk,
    input  logic rst_i,
    tlb_if.tlb   tlb_bus
);

    logic [mmu_pkg::TLB_ENTRIES-1:0] valid_q;
    logic [mmu_pkg::TLB_ENTRIES-1:0] page_4m_q;
    logic [mmu_pkg::VPN_W-1:0]       vpn_q [mmu_pkg::TLB_ENTRIES];
    mmu_pkg::sv32_pte_u              pte_q [mmu_pkg::TLB_ENTRIES];
    logic [mmu_pkg::TLB_IDX_W-1:0]   victim_q;

    logic [mmu_pkg::TLB_ENTRIES-1:0] entry_hit;
    logic [mmu_pkg::TLB_IDX_W-1:0]   hit_idx;
    mmu_pkg::sv32_pte_u              hit_pte;
    logic                            free_found;
    logic [mmu_pkg::TLB_IDX_W-1:0]   fill_idx;

    // Superpage entries ignore the level-0 part of the vpn
    always_comb begin
        for (int i = 0; i < mmu_pkg::TLB_ENTRIES; i++) begin
            entry_hit[i] = valid_q[i]
                && (vpn_q[i][19:10] == tlb_bus.vpn[19:10])
                && (page_4m_q[i] || (vpn_q[i][9:0] == tlb_bus.vpn[9:0]));
        end
    end

    // Lowest matching entry wins
    always_comb begin
        hit_idx = '0;
        for (int i = mmu_pkg::TLB_ENTRIES - 1; i >= 0; i--) begin
            if (entry_hit[i]) begin
                hit_idx = i[mmu_pkg::TLB_IDX_W-1:0];
            end
        end
    end

    assign hit_pte         = pte_q[hit_idx];
    assign tlb_bus.match   = tlb_bus.req & (|entry_hit);
    assign tlb_bus.ppn     = hit_pte.flat.ppn;
    assign tlb_bus.page_4m = page_4m_q[hit_idx];
    assign tlb_bus.r       = hit_pte.flat.r;
    assign tlb_bus.w       = hit_pte.flat.w;
    assign tlb_bus.x       = hit_pte.flat.x;

    // First free slot, else the round-robin victim
    always_comb begin
        free_found = 1'b0;
        fill_idx   = victim_q;
        for (int i = mmu_pkg::TLB_ENTRIES - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                free_found = 1'b1;
                fill_idx   = i[mmu_pkg::TLB_IDX_W-1:0];
            end
        end
    end

    // Flush takes priority over a fill in the same cycle
    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q  <= '0;
            victim_q <= '0;
        end else if (tlb_bus.flush) begin
            valid_q <= '0;
        end else if (tlb_bus.fill) begin
            valid_q[fill_idx] <= 1'b1;
            if (!free_found) begin
                victim_q <= victim_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tlb_bus.fill && !tlb_bus.flush) begin
            vpn_q[fill_idx]     <= tlb_bus.fill_vpn;
            pte_q[fill_idx]     <= tlb_bus.fill_pte;
            page_4m_q[fill_idx] <= tlb_bus.fill_4m;
        end
    end

endmodule

// ==== hdl/ptw.sv ====
////////////////////////////////////////
// Two-level Sv32 page-table walker
// Serves ITLB and DTLB misses over the data-cache port
////////////////////////////////////////

`timescale 1ns/1ns

module ptw (
    input  logic                      clk,
    input  logic                      rst_i,
    input  logic [mmu_pkg::PPN_W-1:0] satp_ppn_i,
    input  logic                      mxr_i,
    input  logic                      i_miss_i,
    input  logic [mmu_pkg::VALEN-1:0] i_vaddr_i,
    input  logic                      d_miss_i,
    input  logic [mmu_pkg::VALEN-1:0] d_vaddr_i,
    input  logic                      is_store_i,
    tlb_if.walker                     itlb,
    tlb_if.walker                     dtlb,
    output logic                      pte_error_o,
    output logic                      iwalk_active_o,
    output logic                      ptw2dcache_req_o,
    output logic [mmu_pkg::PALEN-1:0] ptw2dcache_addr_o,
    input  logic                      dcache2ptw_ack_i,
    input  logic [31:0]               dcache2ptw_rdata_i
);

    mmu_pkg::ptw_state_e       state_q;
    mmu_pkg::ptw_state_e       state_d;
    logic [mmu_pkg::VALEN-1:0] vaddr_q;
    logic                      iwalk_q;
    logic                      store_q;
    logic                      leaf_4m_q;
    mmu_pkg::sv32_pte_u        pte_q;

    mmu_pkg::sv32_pte_u        rd_pte;
    logic                      rd_leaf;
    logic                      rd_allowed;
    logic                      rd_bad;
    logic                      walking;

    assign rd_pte  = dcache2ptw_rdata_i;
    assign rd_leaf = rd_pte.flat.r | rd_pte.flat.x;
    assign walking = (state_q == mmu_pkg::L1_REQ) || (state_q == mmu_pkg::L0_REQ);

    // Access rule for the walk in flight
    always_comb begin
        if (iwalk_q) begin
            rd_allowed = rd_pte.flat.x;
        end else if (store_q) begin
            rd_allowed = rd_pte.flat.w;
        end else begin
            rd_allowed = rd_pte.flat.r | (mxr_i & rd_pte.flat.x);
        end
    end

    always_comb begin
        rd_bad = !rd_pte.flat.v || (rd_pte.flat.w && !rd_pte.flat.r);
        if (rd_leaf) begin
            // Superpage must be aligned to 4 MiB
            rd_bad = rd_bad || !rd_allowed
                || ((state_q == mmu_pkg::L1_REQ) && (rd_pte.split.ppn0 != '0));
        end else if (state_q == mmu_pkg::L0_REQ) begin
            rd_bad = 1'b1;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            mmu_pkg::IDLE: begin
                if (i_miss_i || d_miss_i) begin
                    state_d = mmu_pkg::L1_REQ;
                end
            end
            mmu_pkg::L1_REQ, mmu_pkg::L0_REQ: begin
                if (dcache2ptw_ack_i) begin
                    if (rd_bad) begin
                        state_d = mmu_pkg::IDLE;
                    end else if (rd_leaf) begin
                        state_d = mmu_pkg::FILL;
                    end else begin
                        state_d = mmu_pkg::L0_REQ;
                    end
                end
            end
            default: begin
                state_d = mmu_pkg::IDLE;
            end
        endcase
    end

    // Fetch wins when both sides miss together
    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= mmu_pkg::IDLE;
            iwalk_q <= 1'b0;
            store_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == mmu_pkg::IDLE) begin
                if (i_miss_i) begin
                    iwalk_q <= 1'b1;
                    store_q <= 1'b0;
                end else if (d_miss_i) begin
                    iwalk_q <= 1'b0;
                    store_q <= is_store_i;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == mmu_pkg::IDLE) begin
            vaddr_q <= i_miss_i ? i_vaddr_i : d_vaddr_i;
        end
        if (walking && dcache2ptw_ack_i) begin
            pte_q     <= rd_pte;
            leaf_4m_q <= (state_q == mmu_pkg::L1_REQ);
        end
    end

    // PTE address from satp at level 1, from the pointer PTE at level 0
    always_comb begin
        if (state_q == mmu_pkg::L0_REQ) begin
            ptw2dcache_addr_o = {pte_q.flat.ppn, vaddr_q[21:12], 2'b00};
        end else begin
            ptw2dcache_addr_o = {satp_ppn_i, vaddr_q[31:22], 2'b00};
        end
    end

    assign ptw2dcache_req_o = walking;
    assign pte_error_o      = walking & dcache2ptw_ack_i & rd_bad;
    assign iwalk_active_o   = iwalk_q;

    assign itlb.fill     = (state_q == mmu_pkg::FILL) & iwalk_q;
    assign itlb.fill_vpn = vaddr_q[31:12];
    assign itlb.fill_pte = pte_q;
    assign itlb.fill_4m  = leaf_4m_q;

    assign dtlb.fill     = (state_q == mmu_pkg::FILL) & ~iwalk_q;
    assign dtlb.fill_vpn = vaddr_q[31:12];
    assign dtlb.fill_pte = pte_q;
    assign dtlb.fill_4m  = leaf_4m_q;

endmodule

// ==== hdl/mmu.sv ====
////////////////////////////////////////
// Sv32 MMU top for fetch and load/store
// Two TLBs plus a shared walker on the data-cache port
////////////////////////////////////////

`timescale 1ns/1ns

module mmu (
    input  logic                      clk,
    input  logic                      rst_i,
    input  logic                      en_vaddr_i,
    input  logic                      en_ld_st_vaddr_i,
    input  logic                      mxr_i,
    input  logic [mmu_pkg::PPN_W-1:0] satp_ppn_i,
    input  logic                      tlb_flush_i,
    input  logic                      i_req_i,
    input  logic [mmu_pkg::VALEN-1:0] i_vaddr_i,
    input  logic                      d_req_i,
    input  logic [mmu_pkg::VALEN-1:0] d_vaddr_i,
    input  logic                      st_req_i,
    input  logic                      dcache2ptw_ack_i,
    input  logic [31:0]               dcache2ptw_rdata_i,
    output logic [mmu_pkg::PALEN-1:0] i_paddr_o,
    output logic                      i_hit_o,
    output logic                      i_page_fault_o,
    output logic [mmu_pkg::PALEN-1:0] d_paddr_o,
    output logic                      d_hit_o,
    output logic                      ld_page_fault_o,
    output logic                      st_page_fault_o,
    output logic                      ptw2dcache_req_o,
    output logic [mmu_pkg::PALEN-1:0] ptw2dcache_addr_o
);

    tlb_if itlb_if ();
    tlb_if dtlb_if ();

    logic i_permit;
    logic d_permit;
    logic i_miss;
    logic d_miss;
    logic pte_error;
    logic iwalk_active;

    // Superpages keep vaddr[21:12] in the physical address
    function automatic logic [mmu_pkg::PALEN-1:0] form_paddr(
        input logic                      xlate,
        input logic [mmu_pkg::PPN_W-1:0] ppn,
        input logic                      page_4m,
        input logic [mmu_pkg::VALEN-1:0] vaddr
    );
        logic [mmu_pkg::PALEN-1:0] pa;
        pa = {2'b00, vaddr};
        if (xlate) begin
            pa = {ppn, vaddr[11:0]};
            if (page_4m) begin
                pa[21:12] = vaddr[21:12];
            end
        end
        return pa;
    endfunction

    assign itlb_if.req   = i_req_i;
    assign itlb_if.vpn   = i_vaddr_i[31:12];
    assign itlb_if.flush = tlb_flush_i;

    assign dtlb_if.req   = d_req_i;
    assign dtlb_if.vpn   = d_vaddr_i[31:12];
    assign dtlb_if.flush = tlb_flush_i;

    tlb itlb_module (
        .clk     (clk),
        .rst_i   (rst_i),
        .tlb_bus (itlb_if.tlb)
    );

    tlb dtlb_module (
        .clk     (clk),
        .rst_i   (rst_i),
        .tlb_bus (dtlb_if.tlb)
    );

    // A match only counts as a hit when the access kind is allowed
    assign i_permit = itlb_if.match & itlb_if.x;
    assign d_permit = dtlb_if.match
        & (st_req_i ? dtlb_if.w : (dtlb_if.r | (mxr_i & dtlb_if.x)));

    assign i_hit_o   = en_vaddr_i ? i_permit : i_req_i;
    assign d_hit_o   = en_ld_st_vaddr_i ? d_permit : d_req_i;
    assign i_paddr_o = form_paddr(en_vaddr_i, itlb_if.ppn, itlb_if.page_4m, i_vaddr_i);
    assign d_paddr_o = form_paddr(en_ld_st_vaddr_i, dtlb_if.ppn, dtlb_if.page_4m, d_vaddr_i);

    assign i_miss = i_req_i & en_vaddr_i & ~i_permit;
    assign d_miss = d_req_i & en_ld_st_vaddr_i & ~d_permit;

    ptw ptw_module (
        .clk                (clk),
        .rst_i              (rst_i),
        .satp_ppn_i         (satp_ppn_i),
        .mxr_i              (mxr_i),
        .i_miss_i           (i_miss),
        .i_vaddr_i          (i_vaddr_i),
        .d_miss_i           (d_miss),
        .d_vaddr_i          (d_vaddr_i),
        .is_store_i         (st_req_i),
        .itlb               (itlb_if.walker),
        .dtlb               (dtlb_if.walker),
        .pte_error_o        (pte_error),
        .iwalk_active_o     (iwalk_active),
        .ptw2dcache_req_o   (ptw2dcache_req_o),
        .ptw2dcache_addr_o  (ptw2dcache_addr_o),
        .dcache2ptw_ack_i   (dcache2ptw_ack_i),
        .dcache2ptw_rdata_i (dcache2ptw_rdata_i)
    );

    // Walker error goes to the side that walked; data side split by store
    always_comb begin
        i_page_fault_o  = 1'b0;
        st_page_fault_o = 1'b0;
        ld_page_fault_o = 1'b0;
        if (pte_error) begin
            if (iwalk_active) begin
                i_page_fault_o = 1'b1;
            end else if (st_req_i) begin
                st_page_fault_o = 1'b1;
            end else if (d_req_i) begin
                ld_page_fault_o = 1'b1;
            end
        end
    end

endmodule

// ==== dv/pt_mem_model.sv ====
////////////////////////////////////////
// Page-table memory for the MMU testbench
// Answers walker reads after random delays
// and gives the expected translation of a vaddr
////////////////////////////////////////

`timescale 1ns/1ns

module pt_mem_model (
    input  logic        clk,
    input  logic        rst_i,
    input  logic        req_i,
    input  logic [33:0] addr_i,
    output logic        ack_o,
    output logic [31:0] rdata_o,
    output logic [21:0] satp_ppn_o
);

    localparam logic [21:0] ROOT_PPN = 22'h00100;
    localparam logic [21:0] L0_BASE  = 22'h00200;

    logic [31:0] mem [logic [33:0]];
    integer      seed;
    int          read_count;
    logic [1:0]  delay_q;

    assign satp_ppn_o = ROOT_PPN;

    function automatic logic [31:0] read_word(input logic [33:0] addr);
        return mem.exists(addr) ? mem[addr] : 32'h0;
    endfunction

    // Flags X W R V come from xwr with the upper flag bits zero
    function automatic logic [31:0] make_pte(input logic [21:0] ppn, input logic [2:0] xwr);
        return {ppn, 6'b000000, xwr, 1'b1};
    endfunction

    // Root table covers vpn1 0..15 with pointers, superpages, misaligned or absent entries
    initial begin
        integer k;
        ack_o      = 1'b0;
        rdata_o    = 32'h0;
        delay_q    = 2'd0;
        seed       = 19;
        read_count = 0;
        for (int v1 = 0; v1 < 16; v1++) begin
            k = {$random(seed)} % 8;
            if (k < 4) begin
                mem[{ROOT_PPN, 10'(v1), 2'b00}] = make_pte(L0_BASE + 22'(v1), 3'b000);
                for (int v0 = 0; v0 < 16; v0++) begin
                    // A k of 0 leaves a pointer at level 0 and a k of 8 leaves no entry
                    k = {$random(seed)} % 9;
                    if (k < 8) begin
                        mem[{L0_BASE + 22'(v1), 10'(v0), 2'b00}] =
                            make_pte(22'($random(seed)), 3'(k));
                    end
                end
            end else if (k < 6) begin
                mem[{ROOT_PPN, 10'(v1), 2'b00}] =
                    make_pte({12'($random(seed)), 10'h000}, 3'(1 + {$random(seed)} % 7));
            end else if (k == 6) begin
                mem[{ROOT_PPN, 10'(v1), 2'b00}] =
                    make_pte({12'($random(seed)), 10'h001}, 3'b011);
            end
        end
    end

    // One read at a time with the ack after 0 to 3 extra cycles
    always @(posedge clk) begin
        if (rst_i) begin
            ack_o   <= 1'b0;
            rdata_o <= 32'h0;
            delay_q <= 2'd0;
        end else if (ack_o) begin
            ack_o   <= 1'b0;
            delay_q <= 2'($random(seed));
        end else if (req_i) begin
            if (delay_q == 2'd0) begin
                ack_o      <= 1'b1;
                rdata_o    <= read_word(addr_i);
                read_count <= read_count + 1;
            end else begin
                delay_q <= delay_q - 2'd1;
            end
        end
    end

    // Kind 0 is a fetch, 1 a load and 2 a store
    // Levels counts the table reads of the walk
    function automatic void ref_translate(
        input  logic [31:0] va,
        input  int          kind,
        input  bit          xlate,
        input  bit          mxr,
        output logic [33:0] pa,
        output bit          fault,
        output int          levels
    );
        logic [31:0] pte;
        bit          allowed;
        pa     = {2'b00, va};
        fault  = 1'b0;
        levels = 0;
        if (!xlate) begin
            return;
        end
        pte    = read_word({ROOT_PPN, va[31:22], 2'b00});
        levels = 1;
        pa     = {pte[31:20], va[21:0]};
        if (pte[0] && (pte[3:1] == 3'b000)) begin
            pte    = read_word({pte[31:10], va[21:12], 2'b00});
            levels = 2;
            pa     = {pte[31:10], va[11:0]};
        end
        if (kind == 0) begin
            allowed = pte[3];
        end else if (kind == 2) begin
            allowed = pte[2];
        end else begin
            allowed = pte[1] || (mxr && pte[3]);
        end
        fault = !pte[0] || (pte[2] && !pte[1]) || !(pte[1] || pte[3]) || !allowed
            || ((levels == 1) && (pte[19:10] != 10'h0));
    endfunction

endmodule

// ==== dv/mmu_tb.sv ====
////////////////////////////////////////
// Testbench for the MMU with bare, translated, flush
// and concurrent fetch/data requests against a model
////////////////////////////////////////

`timescale 1ns/1ns

module mmu_tb;

    localparam int TIMEOUT_CYCLES = 12000;

    logic        clk;
    logic        rst_i;
    logic        en_vaddr_i;
    logic        en_ld_st_vaddr_i;
    logic        mxr_i;
    logic [21:0] satp_ppn;
    logic        tlb_flush_i;
    logic        i_req_i;
    logic [31:0] i_vaddr_i;
    logic        d_req_i;
    logic [31:0] d_vaddr_i;
    logic        st_req_i;
    logic        ack;
    logic [31:0] rdata;
    logic [33:0] i_paddr_o;
    logic        i_hit_o;
    logic        i_page_fault_o;
    logic [33:0] d_paddr_o;
    logic        d_hit_o;
    logic        ld_page_fault_o;
    logic        st_page_fault_o;
    logic        walk_req;
    logic [33:0] walk_addr;
    integer      seed;
    int          cycle_count;

    mmu uut (
        .clk                (clk),
        .rst_i              (rst_i),
        .en_vaddr_i         (en_vaddr_i),
        .en_ld_st_vaddr_i   (en_ld_st_vaddr_i),
        .mxr_i              (mxr_i),
        .satp_ppn_i         (satp_ppn),
        .tlb_flush_i        (tlb_flush_i),
        .i_req_i            (i_req_i),
        .i_vaddr_i          (i_vaddr_i),
        .d_req_i            (d_req_i),
        .d_vaddr_i          (d_vaddr_i),
        .st_req_i           (st_req_i),
        .dcache2ptw_ack_i   (ack),
        .dcache2ptw_rdata_i (rdata),
        .i_paddr_o          (i_paddr_o),
        .i_hit_o            (i_hit_o),
        .i_page_fault_o     (i_page_fault_o),
        .d_paddr_o          (d_paddr_o),
        .d_hit_o            (d_hit_o),
        .ld_page_fault_o    (ld_page_fault_o),
        .st_page_fault_o    (st_page_fault_o),
        .ptw2dcache_req_o   (walk_req),
        .ptw2dcache_addr_o  (walk_addr)
    );

    pt_mem_model mem_model (
        .clk        (clk),
        .rst_i      (rst_i),
        .req_i      (walk_req),
        .addr_i     (walk_addr),
        .ack_o      (ack),
        .rdata_o    (rdata),
        .satp_ppn_o (satp_ppn)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Simulation timed out after %0d cycles", cycle_count);
            $display("Checks failed");
            $fatal(1);
        end
    end

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("Error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    // vpn1 and vpn0 limited to 0..15 so pages repeat
    function automatic logic [31:0] rand_va();
        return $random(seed) & 32'h03C0_FFFF;
    endfunction

    task automatic flush_tlbs();
        @(posedge clk);
        tlb_flush_i <= 1'b1;
        @(posedge clk);
        tlb_flush_i <= 1'b0;
    endtask

    // Walk mode 1 expects a full walk and mode 2 a same-cycle hit with no reads
    task automatic issue(input bit do_i, input logic [31:0] iva, input bit do_d,
                         input int dkind, input logic [31:0] dva, input bit xl,
                         input bit mx, input int walk_mode, output bit any_fault);
        logic [33:0] ipa;
        logic [33:0] dpa;
        bit          ifl;
        bit          dfl;
        int          ilv;
        int          dlv;
        int          r0;
        int          waited;
        bit          ipend;
        bit          dpend;
        ilv = 0;
        dlv = 0;
        ifl = 1'b0;
        dfl = 1'b0;
        if (do_i) mem_model.ref_translate(iva, 0, xl, mx, ipa, ifl, ilv);
        if (do_d) mem_model.ref_translate(dva, dkind, xl, mx, dpa, dfl, dlv);
        any_fault = ifl | dfl;
        @(posedge clk);
        r0 = mem_model.read_count;
        en_vaddr_i       <= xl;
        en_ld_st_vaddr_i <= xl;
        mxr_i            <= mx;
        i_req_i          <= do_i;
        i_vaddr_i        <= iva;
        d_req_i          <= do_d;
        d_vaddr_i        <= dva;
        st_req_i         <= do_d && (dkind == 2);
        ipend  = do_i;
        dpend  = do_d;
        waited = 0;
        while (ipend || dpend) begin
            @(negedge clk);
            if (ipend && (i_hit_o || i_page_fault_o)) begin
                check_value("fetch fault", 64'(i_page_fault_o), 64'(ifl));
                check_value("fetch hit", 64'(i_hit_o), 64'(!ifl));
                if (!ifl) check_value("fetch paddr", 64'(i_paddr_o), 64'(ipa));
                ipend = 1'b0;
            end
            if (dpend && (d_hit_o || ld_page_fault_o || st_page_fault_o)) begin
                check_value("data fault kind", 64'({ld_page_fault_o, st_page_fault_o}),
                            64'({dfl && (dkind == 1), dfl && (dkind == 2)}));
                check_value("data hit", 64'(d_hit_o), 64'(!dfl));
                if (!dfl) check_value("data paddr", 64'(d_paddr_o), 64'(dpa));
                dpend = 1'b0;
            end
            if (walk_mode == 2) check_value("hit latency", 64'(waited), 64'd0);
            waited++;
            @(posedge clk);
            if (!ipend) i_req_i <= 1'b0;
            if (!dpend) begin
                d_req_i  <= 1'b0;
                st_req_i <= 1'b0;
            end
        end
        if (walk_mode == 1) begin
            check_value("walk reads", 64'(mem_model.read_count - r0), 64'(ilv + dlv));
        end else if (walk_mode == 2) begin
            check_value("reads on hit", 64'(mem_model.read_count - r0), 64'd0);
        end
    endtask

    initial begin
        bit          f;
        int          kind;
        bit          mx;
        logic [31:0] va;
        logic [31:0] va2;
        seed             = 19;
        cycle_count      = 0;
        rst_i            = 1'b1;
        en_vaddr_i       = 1'b0;
        en_ld_st_vaddr_i = 1'b0;
        mxr_i            = 1'b0;
        tlb_flush_i      = 1'b0;
        i_req_i          = 1'b0;
        i_vaddr_i        = 32'h0;
        d_req_i          = 1'b0;
        d_vaddr_i        = 32'h0;
        st_req_i         = 1'b0;
        repeat (3) @(posedge clk);
        rst_i <= 1'b0;

        // Bare mode passes addresses through
        repeat (20) begin
            kind = {$random(seed)} % 3;
            va   = $random(seed);
            issue(kind == 0, va, kind != 0, kind, va, 1'b0, 1'b0, 2, f);
        end

        // Translated accesses with each hit repeated without a walk
        for (int n = 0; n < 120; n++) begin
            if (n % 8 == 0) flush_tlbs();
            kind = {$random(seed)} % 3;
            va   = rand_va();
            mx   = 1'($random(seed));
            issue(kind == 0, va, kind != 0, kind, va, 1'b1, mx, (n % 8 == 0) ? 1 : 0, f);
            if (!f) begin
                issue(kind == 0, va, kind != 0, kind, va, 1'b1, mx, 2, f);
                // A cached page walks again after a flush
                if (n % 4 == 3) begin
                    flush_tlbs();
                    issue(kind == 0, va, kind != 0, kind, va, 1'b1, mx, 1, f);
                end
            end
        end

        // Fetch and data miss together after a flush
        repeat (20) begin
            flush_tlbs();
            va   = rand_va();
            va2  = rand_va();
            kind = 1 + {$random(seed)} % 2;
            mx   = 1'($random(seed));
            issue(1'b1, va, 1'b1, kind, va2, 1'b1, mx, 1, f);
        end

        $display("All checks passed");
        $finish;
    end

endmodule

// ==== all.f ====
hdl/mmu_pkg.sv
hdl/tlb_if.sv
hdl/tlb.sv
hdl/ptw.sv
hdl/mmu.sv
dv/pt_mem_model.sv
dv/mmu_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile the MMU testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f all.f --top-module mmu_tb -o mmu_sim

./obj_dir/mmu_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "All checks passed" sim.log; then
    exit 0
fi
exit 1
